// ==== build.f ====
+incdir+tb
rtl/rv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/exec_decode.sv
rtl/exec_alu.sv
rtl/exec_muldiv.sv
rtl/exec_stage.sv
tb/exec_stage_chk.sv
tb/tb_exec_stage.sv

// ==== rtl/exec_alu.sv ====
`timescale 1ns/1ns

module exec_alu
    import rv_isa_pkg::*;
(
    input  instr_u          instr,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] result,
    output logic            illegal,
    output logic            branch_taken
);

    logic            is_op;
    logic            is_op_imm;
    logic            is_branch;
    logic            alt;
    logic [XLEN-1:0] opb;
    logic [4:0]      shamt;

    assign is_op     = (instr.r.opcode == OPCODE_OP);
    assign is_op_imm = (instr.r.opcode == OPCODE_OP_IMM);
    assign is_branch = (instr.r.opcode == OPCODE_BRANCH);
    assign alt       = (instr.r.funct7 == FUNCT7_ALT);

    assign opb   = is_op ? rs2 : imm;
    assign shamt = is_op ? rs2[4:0] : instr.i.imm_11_0[4:0];

    always_comb begin
        case (instr.r.funct3)
            3'b000: result = (is_op && alt) ? rs1 - opb : rs1 + opb;
            3'b001: result = rs1 << shamt;
            3'b010: result = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(opb)};
            3'b011: result = {{(XLEN-1){1'b0}}, rs1 < opb};
            3'b100: result = rs1 ^ opb;
            3'b101: result = alt ? XLEN'($signed(rs1) >>> shamt) : rs1 >> shamt;
            3'b110: result = rs1 | opb;
            default: result = rs1 & opb;
        endcase
    end

    // ALT funct7 is only legal on SUB and the arithmetic right shifts
    always_comb begin
        illegal = 1'b0;
        if (is_op) begin
            illegal = !(instr.r.funct7 == FUNCT7_BASE ||
                        (alt && (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101)));
        end else if (is_op_imm && instr.r.funct3 == 3'b001) begin
            illegal = (instr.r.funct7 != FUNCT7_BASE);
        end else if (is_op_imm && instr.r.funct3 == 3'b101) begin
            illegal = !(instr.r.funct7 == FUNCT7_BASE || alt);
        end else if (is_branch) begin
            illegal = (instr.b.funct3[2:1] == 2'b01);
        end
    end

    always_comb begin
        case (instr.b.funct3)
            3'b000: branch_taken = (rs1 == rs2);
            3'b001: branch_taken = (rs1 != rs2);
            3'b100: branch_taken = ($signed(rs1) < $signed(rs2));
            3'b101: branch_taken = ($signed(rs1) >= $signed(rs2));
            3'b110: branch_taken = (rs1 < rs2);
            3'b111: branch_taken = (rs1 >= rs2);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/exec_decode.sv ====
`timescale 1ns/1ns

module exec_decode
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  instr_u   instr,
    output decoded_t decoded
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Immediate formats, sign taken from bit 31
    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'h000};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        decoded.funct3   = instr.r.funct3;
        decoded.imm      = imm_i;
        decoded.op_class = ILLEGAL;
        case (instr.r.opcode)
            OPCODE_OP: begin
                // M extension shares the OP opcode
                if (instr.r.funct7 == FUNCT7_MULDIV) begin
                    decoded.op_class = MULDIV;
                end else begin
                    decoded.op_class = ALU;
                end
            end
            OPCODE_OP_IMM: begin
                decoded.op_class = ALU;
            end
            OPCODE_LUI: begin
                decoded.op_class = LUI;
                decoded.imm      = imm_u;
            end
            OPCODE_AUIPC: begin
                decoded.op_class = AUIPC;
                decoded.imm      = imm_u;
            end
            OPCODE_JAL: begin
                decoded.op_class = JAL;
                decoded.imm      = imm_j;
            end
            OPCODE_JALR: begin
                if (instr.i.funct3 == 3'b000) begin
                    decoded.op_class = JALR;
                end
            end
            OPCODE_BRANCH: begin
                decoded.op_class = BRANCH;
                decoded.imm      = imm_b;
            end
            default: begin
                decoded.op_class = ILLEGAL;
            end
        endcase
    end

endmodule

// ==== rtl/exec_muldiv.sv ====
`timescale 1ns/1ns

module exec_muldiv
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req,
    input  muldiv_op_t      op,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    output logic            done,
    output logic [XLEN-1:0] result
);

    logic                busy;
    logic [4:0]          cnt;
    logic [2*XLEN-1:0]   acc;
    logic [XLEN-1:0]     divisor_q;
    muldiv_op_t          op_q;
    logic                neg_q;

    logic                a_neg;
    logic                b_neg;
    logic                start;
    logic [XLEN:0]       mul_sum;
    logic [XLEN:0]       partial;
    logic [XLEN+1:0]     diff;
    logic [2*XLEN-1:0]   acc_neg;

    assign a_neg = rs1[XLEN-1] && (op inside {MUL, MULH, MULHSU, DIV, REM});
    assign b_neg = rs2[XLEN-1] && (op inside {MUL, MULH, DIV, REM});
    assign start = req && !busy && !done;

    // Shift-add step, acc holds {product high, multiplier low}
    assign mul_sum = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, divisor_q} : '0);

    // Restoring step, acc holds {remainder, quotient}
    assign partial = acc[2*XLEN-1:XLEN-1];
    assign diff    = {1'b0, partial} - {2'b00, divisor_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 5'd1;
                if (cnt == 5'd31) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Operands go in as magnitudes; the sign is fixed up at the end
    always_ff @(posedge clk) begin
        if (start) begin
            acc       <= {{XLEN{1'b0}}, a_neg ? -rs1 : rs1};
            divisor_q <= b_neg ? -rs2 : rs2;
            op_q      <= op;
            // Divide by zero keeps the all-ones quotient unsigned
            if (op inside {REM, REMU}) begin
                neg_q <= a_neg;
            end else begin
                neg_q <= (a_neg ^ b_neg) && !(op[2] && rs2 == '0);
            end
        end else if (busy) begin
            if (!op_q[2]) begin
                acc <= {mul_sum, acc[XLEN-1:1]};
            end else if (!diff[XLEN+1]) begin
                acc <= {diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
            end else begin
                acc <= {partial[XLEN-1:0], acc[XLEN-2:0], 1'b0};
            end
        end
    end

    // MIN/-1 needs no special case: 0x80000000 unsigned over 1 with no sign flip
    assign acc_neg = -acc;

    always_comb begin
        case (op_q)
            MUL:           result = neg_q ? acc_neg[XLEN-1:0] : acc[XLEN-1:0];
            MULH, MULHSU:  result = neg_q ? acc_neg[2*XLEN-1:XLEN] : acc[2*XLEN-1:XLEN];
            MULHU:         result = acc[2*XLEN-1:XLEN];
            DIV, DIVU:     result = neg_q ? -acc[XLEN-1:0] : acc[XLEN-1:0];
            default:       result = neg_q ? -acc[2*XLEN-1:XLEN] : acc[2*XLEN-1:XLEN];
        endcase
    end

endmodule

// ==== rtl/exec_pkg.sv ====
package exec_pkg;

    import rv_isa_pkg::*;

    // Command back to fetch/decode
    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        BRANCH_TAKEN = 2'd1
    } e2d_cmd_t;

    typedef enum logic [2:0] {
        ALU,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BRANCH,
        MULDIV,
        ILLEGAL
    } op_class_t;

    // Encoded exactly as funct3 of the M extension
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } muldiv_op_t;

    typedef struct packed {
        instr_u          instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
    } exec_req_t;

    typedef struct packed {
        logic                  ready;
        e2d_cmd_t              cmd;
        logic [XLEN-1:0]       branch_target;
        logic                  rd_write;
        logic [REG_ADDR_W-1:0] rd_waddr;
        logic [XLEN-1:0]       rd_wdata;
        logic                  illegal;
    } exec_resp_t;

    typedef struct packed {
        op_class_t       op_class;
        logic [XLEN-1:0] imm;
        logic [2:0]      funct3;
    } decoded_t;

endpackage

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       d2e_valid,
    input  exec_req_t  d2e_req,
    output exec_resp_t e2d_resp
);

    decoded_t        dec;
    logic [XLEN-1:0] alu_result;
    logic            alu_illegal;
    logic            alu_branch_taken;
    logic            md_req;
    logic            md_done;
    logic [XLEN-1:0] md_result;

    logic            branch_phase;
    logic            branch_taken_q;
    logic            done_now;
    logic            wr_en;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] jalr_target;
    logic [XLEN-1:0] pc_plus_4;

    exec_decode u_decode (
        .instr   (d2e_req.instr),
        .decoded (dec)
    );

    exec_alu u_alu (
        .instr        (d2e_req.instr),
        .rs1          (d2e_req.rs1),
        .rs2          (d2e_req.rs2),
        .imm          (dec.imm),
        .result       (alu_result),
        .illegal      (alu_illegal),
        .branch_taken (alu_branch_taken)
    );

    assign md_req = d2e_valid && (dec.op_class == MULDIV);

    exec_muldiv u_muldiv (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (md_req),
        .op     (muldiv_op_t'(dec.funct3)),
        .rs1    (d2e_req.rs1),
        .rs2    (d2e_req.rs2),
        .done   (md_done),
        .result (md_result)
    );

    // One adder serves branch, JAL and AUIPC targets
    assign pc_imm      = d2e_req.pc + dec.imm;
    assign jalr_target = (d2e_req.rs1 + dec.imm) & ~{{(XLEN-1){1'b0}}, 1'b1};
    assign pc_plus_4   = d2e_req.pc + 32'd4;

    // Branch takes two cycles, condition is captured in the first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            branch_phase <= 1'b0;
        end else if (d2e_valid && dec.op_class == BRANCH && !alu_illegal) begin
            branch_phase <= !branch_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (d2e_valid && !branch_phase) begin
            branch_taken_q <= alu_branch_taken;
        end
    end

    always_comb begin
        done_now                = 1'b1;
        wr_en                   = 1'b1;
        e2d_resp.cmd            = IDLE;
        e2d_resp.branch_target  = pc_imm;
        e2d_resp.rd_wdata       = alu_result;
        e2d_resp.illegal        = 1'b0;
        case (dec.op_class)
            ALU: begin
                e2d_resp.illegal = alu_illegal;
                wr_en            = !alu_illegal;
            end
            LUI:   e2d_resp.rd_wdata = dec.imm;
            AUIPC: e2d_resp.rd_wdata = pc_imm;
            JAL: begin
                e2d_resp.cmd      = BRANCH_TAKEN;
                e2d_resp.rd_wdata = pc_plus_4;
            end
            JALR: begin
                e2d_resp.cmd           = BRANCH_TAKEN;
                e2d_resp.branch_target = jalr_target;
                e2d_resp.rd_wdata      = pc_plus_4;
                // Misaligned target suppresses the link write
                wr_en                  = !jalr_target[1];
            end
            BRANCH: begin
                wr_en = 1'b0;
                if (alu_illegal) begin
                    e2d_resp.illegal = 1'b1;
                end else begin
                    done_now     = branch_phase;
                    e2d_resp.cmd = (branch_phase && branch_taken_q) ? BRANCH_TAKEN : IDLE;
                end
            end
            MULDIV: begin
                done_now          = md_done;
                e2d_resp.rd_wdata = md_result;
            end
            default: begin
                wr_en            = 1'b0;
                e2d_resp.illegal = 1'b1;
            end
        endcase
        e2d_resp.ready    = d2e_valid && done_now;
        e2d_resp.rd_waddr = d2e_req.instr.r.rd;
        e2d_resp.rd_write = e2d_resp.ready && wr_en && (d2e_req.instr.r.rd != '0);
    end

endmodule

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the execute stage
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_type_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_type_t;

    // One instruction word, seen through each encoding format
    typedef union packed {
        logic [31:0] word;
        r_type_t     r;
        i_type_t     i;
        s_type_t     s;
        b_type_t     b;
        u_type_t     u;
        j_type_t     j;
    } instr_u;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_exec_stage -f build.f -o sim_exec_stage

./obj_dir/sim_exec_stage | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"

// ==== tb/exec_stage_chk.sv ====
`timescale 1ns/1ns

module exec_stage_chk
    import exec_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       d2e_valid,
    input exec_resp_t e2d_resp
);

    // Completion is only ever an answer to a presented request
    a_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        e2d_resp.ready |-> d2e_valid)
        else $error("ready high while d2e_valid is low");

    a_write_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        e2d_resp.rd_write |-> e2d_resp.ready)
        else $error("rd_write high without ready");

    // x0 is never a write target
    a_write_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        e2d_resp.rd_write |-> (e2d_resp.rd_waddr != '0))
        else $error("rd_write high with rd_waddr zero");

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !e2d_resp.ready)
        else $error("ready high during reset");

endmodule

bind exec_stage exec_stage_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .d2e_valid (d2e_valid),
    .e2d_resp  (e2d_resp)
);

// ==== tb/exec_ref_model.svh ====
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Integer result of an OP or OP_IMM instruction
function automatic logic [31:0] alu_expect(logic is_op, logic [2:0] f3, logic alt,
                                           logic [31:0] a, logic [31:0] b, logic [4:0] sh);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        res;
    sa = a;
    sb = b;
    case (f3)
        3'd0: res = (is_op && alt) ? a - b : a + b;
        3'd1: res = a << sh;
        3'd2: res = (sa < sb) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: begin
            if (alt) res = sa >>> sh;
            else res = a >> sh;
        end
        3'd6: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

// M extension, with the divide-by-zero and overflow results
function automatic logic [31:0] muldiv_expect(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [63:0]        p;
    logic               ovf;
    logic [31:0]        res;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (f3)
        3'd1: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        3'd2: p = {{32{a[31]}}, a} * {32'd0, b};
        default: p = {32'd0, a} * {32'd0, b};
    endcase
    case (f3)
        3'd0: res = p[31:0];
        3'd1, 3'd2, 3'd3: res = p[63:32];
        3'd4: begin
            if (b == 32'd0) res = 32'hffff_ffff;
            else if (ovf) res = a;
            else res = sa / sb;
        end
        3'd5: begin
            if (b == 32'd0) res = 32'hffff_ffff;
            else res = a / b;
        end
        3'd6: begin
            if (b == 32'd0) res = a;
            else if (ovf) res = 32'd0;
            else res = sa % sb;
        end
        default: begin
            if (b == 32'd0) res = a;
            else res = a % b;
        end
    endcase
    return res;
endfunction

function automatic logic branch_expect(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               taken;
    sa = a;
    sb = b;
    case (f3)
        3'b000: taken = (a == b);
        3'b001: taken = (a != b);
        3'b100: taken = (sa < sb);
        3'b101: taken = (sa >= sb);
        3'b110: taken = (a < b);
        3'b111: taken = (a >= b);
        default: taken = 1'b0;
    endcase
    return taken;
endfunction

// Encodings outside the kept instruction set
function automatic logic illegal_expect(logic [31:0] w);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       bad;
    opc = w[6:0];
    f7  = w[31:25];
    f3  = w[14:12];
    case (opc)
        OPCODE_OP: bad = !(f7 == FUNCT7_BASE || f7 == FUNCT7_MULDIV ||
                           (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
        OPCODE_OP_IMM: bad = (f3 == 3'd1 && f7 != FUNCT7_BASE) ||
                             (f3 == 3'd5 && f7 != FUNCT7_BASE && f7 != FUNCT7_ALT);
        OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: bad = 1'b0;
        OPCODE_JALR: bad = (f3 != 3'd0);
        OPCODE_BRANCH: bad = (f3 == 3'b010 || f3 == 3'b011);
        default: bad = 1'b1;
    endcase
    return bad;
endfunction

// Full response of the stage once ready is high
function automatic exec_resp_t expect_resp(exec_req_t r);
    exec_resp_t  e;
    logic [31:0] w;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        is_op;
    logic        wr;
    w     = r.instr.word;
    f3    = w[14:12];
    is_op = (w[6:0] == OPCODE_OP);
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    e          = '0;
    e.ready    = 1'b1;
    e.cmd      = IDLE;
    e.rd_waddr = w[11:7];
    e.illegal  = illegal_expect(w);
    wr         = !e.illegal;
    case (w[6:0])
        OPCODE_OP, OPCODE_OP_IMM: begin
            if (is_op && w[31:25] == FUNCT7_MULDIV) begin
                e.rd_wdata = muldiv_expect(f3, r.rs1, r.rs2);
            end else begin
                e.rd_wdata = alu_expect(is_op, f3, w[30], r.rs1, is_op ? r.rs2 : imm_i,
                                        is_op ? r.rs2[4:0] : w[24:20]);
            end
        end
        OPCODE_LUI:   e.rd_wdata = imm_u;
        OPCODE_AUIPC: e.rd_wdata = r.pc + imm_u;
        OPCODE_JAL: begin
            e.cmd           = BRANCH_TAKEN;
            e.branch_target = r.pc + imm_j;
            e.rd_wdata      = r.pc + 32'd4;
        end
        OPCODE_JALR: begin
            e.cmd           = BRANCH_TAKEN;
            e.branch_target = (r.rs1 + imm_i) & 32'hffff_fffe;
            e.rd_wdata      = r.pc + 32'd4;
            wr              = wr && !e.branch_target[1];
        end
        OPCODE_BRANCH: begin
            wr              = 1'b0;
            e.branch_target = r.pc + imm_b;
            if (!e.illegal && branch_expect(f3, r.rs1, r.rs2)) e.cmd = BRANCH_TAKEN;
        end
        default: wr = 1'b0;
    endcase
    e.rd_write = wr && (w[11:7] != 5'd0);
    return e;
endfunction

`endif

// ==== tb/tb_exec_stage.sv ====
`timescale 1ns/1ns

module tb_exec_stage
    import rv_isa_pkg::*, exec_pkg::*;
();

    localparam int WAIT_LIMIT = 100;

    logic       clk;
    logic       rst_n;
    logic       d2e_valid;
    exec_req_t  d2e_req;
    exec_resp_t e2d_resp;

    logic [31:0] lcg_state;
    logic        timed_out;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;

    exec_stage UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .d2e_valid (d2e_valid),
        .d2e_req   (d2e_req),
        .e2d_resp  (e2d_resp)
    );

    `include "exec_ref_model.svh"

    always #20 clk = ~clk;

    // Upper halves of two LCG steps since the low bits cycle too quickly
    function automatic logic [31:0] lcg_next();
        logic [31:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    function automatic exec_req_t make_req(logic [31:0] word);
        exec_req_t   req;
        logic [31:0] pc;
        pc             = lcg_next();
        req.instr.word = word;
        req.pc         = {pc[31:2], 2'b00};
        req.rs1        = lcg_next();
        req.rs2        = lcg_next();
        return req;
    endfunction

    function automatic logic [31:0] branch_word(logic [12:0] imm, logic [4:0] rs2,
                                                logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Present one instruction and hold it until the stage answers
    task automatic run_instr(input exec_req_t req, input int exp_wait);
        exec_resp_t exp;
        int         waited;
        if (!timed_out) begin
            @(negedge clk);
            d2e_valid = 1'b1;
            d2e_req   = req;
            #5;
            waited = 0;
            while (!e2d_resp.ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                #5;
                waited++;
            end
            if (!e2d_resp.ready) begin
                timed_out = 1'b1;
                $display("Timeout: no ready within %0d cycles for instruction %h at %0t ns",
                         WAIT_LIMIT, req.instr.word, $time);
            end else begin
                exp = expect_resp(req);
                if (exp_wait >= 0) check_val("ready latency", waited, exp_wait);
                check_val("e2d_resp.illegal", 32'(e2d_resp.illegal), 32'(exp.illegal));
                check_val("e2d_resp.rd_write", 32'(e2d_resp.rd_write), 32'(exp.rd_write));
                if (exp.rd_write) begin
                    check_val("e2d_resp.rd_waddr", 32'(e2d_resp.rd_waddr), 32'(exp.rd_waddr));
                    check_val("e2d_resp.rd_wdata", e2d_resp.rd_wdata, exp.rd_wdata);
                end
                if (!exp.illegal) begin
                    check_val("e2d_resp.cmd", 32'(e2d_resp.cmd), 32'(exp.cmd));
                    if (exp.cmd == BRANCH_TAKEN) begin
                        check_val("e2d_resp.branch_target", e2d_resp.branch_target,
                                  exp.branch_target);
                    end
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        d2e_valid = 1'b0;
        tests_run++;
        if (errors != test_err_base) tests_failed++;
        $display("Test %s finished with %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    initial begin
        logic [31:0] r;
        exec_req_t   req;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [11:0] imm12;
        clk           = 1'b0;
        rst_n         = 1'b0;
        d2e_valid     = 1'b0;
        d2e_req       = '0;
        lcg_state     = 32'd4;
        timed_out     = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_err_base = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Register and immediate ALU forms with every fifth one aimed at x0
        for (int i = 0; i < 40; i++) begin
            r  = lcg_next();
            f3 = r[2:0];
            rd = (i % 5 == 0) ? 5'd0 : r[7:3];
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[8]) ? FUNCT7_ALT : FUNCT7_BASE;
            if (r[9]) begin
                req = make_req({f7, r[14:10], r[19:15], f3, rd, OPCODE_OP});
            end else begin
                imm12 = r[31:20];
                if (f3 == 3'd1 || f3 == 3'd5) imm12[11:5] = f7;
                req = make_req({imm12, r[19:15], f3, rd, OPCODE_OP_IMM});
            end
            run_instr(req, 0);
        end
        finish_test("alu");

        for (int i = 0; i < 32; i++) begin
            r  = lcg_next();
            rd = r[4:0];
            case (i % 4)
                0: req = make_req({r[31:12], rd, OPCODE_LUI});
                1: req = make_req({r[31:12], rd, OPCODE_AUIPC});
                2: req = make_req(jal_word(r[31:11], rd));
                default: begin
                    req = make_req({r[31:22], 2'b00, r[19:15], 3'b000, rd, OPCODE_JALR});
                    // Target bit 1 follows rs1 bit 1 and alternates between JALRs
                    req.rs1[1] = i[2];
                end
            endcase
            run_instr(req, 0);
        end
        finish_test("upper_jump");

        // Funct3 0,1,4,5,6,7 in turn
        for (int i = 0; i < 36; i++) begin
            r  = lcg_next();
            f3 = 3'(i % 6);
            if (f3 >= 3'd2) f3 = f3 + 3'd2;
            req = make_req(branch_word(r[12:0], r[17:13], r[22:18], f3));
            // Every third round of six uses equal operands
            if ((i / 6) % 3 == 0) req.rs2 = req.rs1;
            run_instr(req, 1);
        end
        finish_test("branch");

        for (int i = 0; i < 56; i++) begin
            r   = lcg_next();
            f3  = 3'(i % 8);
            req = make_req({FUNCT7_MULDIV, r[4:0], r[9:5], f3, r[14:10] | 5'd1, OPCODE_OP});
            if (i >= 40 && i < 48) req.rs2 = '0;
            if (i >= 48) begin
                req.rs1 = 32'h8000_0000;
                req.rs2 = 32'hffff_ffff;
            end
            run_instr(req, -1);
        end
        finish_test("muldiv");

        r = lcg_next();
        run_instr(make_req({r[31:7], 7'b0000011}), 0);
        run_instr(make_req({r[31:7], 7'b1111111}), 0);
        run_instr(make_req({7'b0000010, r[24:15], 3'b000, 5'd1, OPCODE_OP}), 0);
        run_instr(make_req(branch_word(r[12:0], r[17:13], r[22:18], 3'b010)), 0);
        run_instr(make_req({r[31:20], r[19:15], 3'b001, 5'd3, OPCODE_JALR}), 0);
        finish_test("illegal");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
